/* src/ep_pkg.sv */
// Endpoint bridge shared definitions
`default_nettype none

package ep_pkg;

	// --------------------------------------------------
	// Link byte layout
	// --------------------------------------------------
	localparam int BYTE_W = 8;
	localparam int CMD_W  = 3;
	localparam int ADDR_W = 3;
	localparam int TAG_W  = 2;

	// Tag of a host control byte
	localparam logic [TAG_W-1:0] TAG_CTRL = 2'b10;
	// Tag of a header byte sent to the host
	localparam logic [TAG_W-1:0] TAG_HDR  = 2'b11;

	// Command codes carried in control and header bytes
	localparam logic [CMD_W-1:0] CMD_TRIGGER  = 3'd1;
	localparam logic [CMD_W-1:0] CMD_TRANSFER = 3'd2;

	// --------------------------------------------------
	// Message types
	// --------------------------------------------------
	// Control byte from the host, also the outgoing header byte
	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [CMD_W-1:0]  cmd;
		logic [ADDR_W-1:0] addr;
	} ctrl_byte_t;

	// Device side message, request in and delivery out
	typedef struct packed {
		logic [CMD_W-1:0]  cmd;
		logic [ADDR_W-1:0] addr;
		logic [BYTE_W-1:0] payload;
	} dev_msg_t;

	// Current holder of the half duplex host link
	typedef enum logic [1:0] {
		OWNER_NONE = 2'd0,
		OWNER_RX   = 2'd1,
		OWNER_TX   = 2'd2
	} link_owner_t;

	// --------------------------------------------------
	// FSM state encodings
	// --------------------------------------------------
	// Receive decoder
	typedef enum logic [2:0] {
		RX_WAIT_CTRL = 3'd0,
		RX_ACK_CTRL  = 3'd1,
		RX_WAIT_DATA = 3'd2,
		RX_ACK_DATA  = 3'd3,
		RX_RELEASE   = 3'd4
	} rx_state_t;

	// Transmit framer
	typedef enum logic [2:0] {
		TX_IDLE       = 3'd0,
		TX_SKIP       = 3'd1,
		TX_WAIT_GRANT = 3'd2,
		TX_HDR        = 3'd3,
		TX_HDR_GAP    = 3'd4,
		TX_PAY        = 3'd5,
		TX_PAY_GAP    = 3'd6,
		TX_DEV_ACK    = 3'd7
	} tx_state_t;

endpackage

`default_nettype wire

/* src/link_arbiter.sv */
// Host link arbiter
`timescale 1ns/1ps
`default_nettype none

module link_arbiter
	import ep_pkg::*;
(
	input  wire  CLK,
	input  wire  RST_N,
	// Requests from both directions
	input  logic rx_req,
	input  logic tx_want,
	// End of message from the current owner
	input  logic rx_done,
	input  logic tx_done,
	output logic rx_grant,
	output logic tx_grant,
	output logic link_busy
);

	link_owner_t owner_q;
	link_owner_t owner_d;

	// --------------------------------------------------
	// Next owner
	// --------------------------------------------------
	always_comb
	begin
		owner_d = owner_q;
		case (owner_q)
			OWNER_NONE:
			begin
				// Receive side has priority on a tie
				if (rx_req)
					owner_d = OWNER_RX;
				else if (tx_want)
					owner_d = OWNER_TX;
			end
			OWNER_RX:
			begin
				// Held across the gap between control and data bytes
				if (rx_done)
					owner_d = OWNER_NONE;
			end
			OWNER_TX:
			begin
				if (tx_done)
					owner_d = OWNER_NONE;
			end
			default:
				owner_d = OWNER_NONE;
		endcase
	end

	// --------------------------------------------------
	// Owner register and grant decode
	// --------------------------------------------------
	// Grants follow the next owner so they rise with it
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			owner_q   <= OWNER_NONE;
			rx_grant  <= 1'b0;
			tx_grant  <= 1'b0;
			link_busy <= 1'b0;
		end
		else
		begin
			owner_q   <= owner_d;
			rx_grant  <= (owner_d == OWNER_RX);
			tx_grant  <= (owner_d == OWNER_TX);
			// External controller holds off reads while framing
			link_busy <= (owner_d == OWNER_TX);
		end
	end

endmodule

`default_nettype wire

/* src/host_rx_decoder.sv */
// Host receive decoder
`timescale 1ns/1ps
`default_nettype none

module host_rx_decoder
	import ep_pkg::*;
(
	input  wire               CLK,
	input  wire               RST_N,
	// Host byte handshake
	input  logic              rx_req,
	input  logic [BYTE_W-1:0] rx_byte,
	input  logic              rx_grant,
	output logic              rx_ack,
	// End of message toward the arbiter
	output logic              rx_done,
	// Delivery toward the device
	output logic              uc_in_valid,
	output dev_msg_t          uc_in_msg
);

	rx_state_t  state_q;
	ctrl_byte_t ctrl_q;
	logic       byte_take;
	logic       ctrl_ok;
	logic       deliver;

	// New byte offered while the link is ours
	assign byte_take = rx_req && rx_grant;

	// Stored control byte checks
	assign ctrl_ok = (ctrl_q.tag == TAG_CTRL);
	assign deliver = (ctrl_q.cmd == CMD_TRIGGER) || (ctrl_q.cmd == CMD_TRANSFER);

	// One cycle pulse once the final ack is down
	assign rx_done = (state_q == RX_RELEASE);

	// --------------------------------------------------
	// Byte handshake FSM
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			state_q     <= RX_WAIT_CTRL;
			rx_ack      <= 1'b0;
			uc_in_valid <= 1'b0;
		end
		else
		begin
			// Valid lasts only the cycle the data ack rises
			uc_in_valid <= 1'b0;
			case (state_q)
				RX_WAIT_CTRL:
				begin
					if (byte_take)
					begin
						rx_ack  <= 1'b1;
						state_q <= RX_ACK_CTRL;
					end
				end
				RX_ACK_CTRL:
				begin
					if (!rx_req)
					begin
						rx_ack <= 1'b0;
						// Stray byte is dropped here
						if (ctrl_ok)
							state_q <= RX_WAIT_DATA;
						else
							state_q <= RX_RELEASE;
					end
				end
				RX_WAIT_DATA:
				begin
					if (byte_take)
					begin
						rx_ack      <= 1'b1;
						uc_in_valid <= deliver;
						state_q     <= RX_ACK_DATA;
					end
				end
				RX_ACK_DATA:
				begin
					if (!rx_req)
					begin
						rx_ack  <= 1'b0;
						state_q <= RX_RELEASE;
					end
				end
				RX_RELEASE:
					state_q <= RX_WAIT_CTRL;
				default:
					state_q <= RX_WAIT_CTRL;
			endcase
		end
	end

	// --------------------------------------------------
	// Control byte and delivered message
	// --------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if ((state_q == RX_WAIT_CTRL) && byte_take)
			ctrl_q <= ctrl_byte_t'(rx_byte);
		if ((state_q == RX_WAIT_DATA) && byte_take)
		begin
			uc_in_msg.cmd     <= ctrl_q.cmd;
			// Trigger carries no address
			uc_in_msg.addr    <= (ctrl_q.cmd == CMD_TRIGGER) ? '0 : ctrl_q.addr;
			uc_in_msg.payload <= rx_byte;
		end
	end

endmodule

`default_nettype wire

/* src/host_tx_framer.sv */
// Host transmit framer
`timescale 1ns/1ps
`default_nettype none

module host_tx_framer
	import ep_pkg::*;
(
	input  wire               CLK,
	input  wire               RST_N,
	// Device request handshake
	input  logic              dev_req,
	input  dev_msg_t          dev_msg,
	output logic              dev_ack,
	// Arbiter side
	output logic              tx_want,
	input  logic              tx_grant,
	// Host byte handshake
	output logic              tx_req,
	output logic [BYTE_W-1:0] tx_byte,
	input  logic              tx_ack,
	output logic              tx_done
);

	tx_state_t  state_q;
	dev_msg_t   msg_q;
	ctrl_byte_t hdr_byte;
	logic       framed;

	// Only trigger and transfer go out on the link
	assign framed = (dev_msg.cmd == CMD_TRIGGER) || (dev_msg.cmd == CMD_TRANSFER);

	// Header byte from the latched request
	assign hdr_byte = '{tag: TAG_HDR, cmd: msg_q.cmd, addr: msg_q.addr};

	// --------------------------------------------------
	// Frame FSM
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			state_q <= TX_IDLE;
			dev_ack <= 1'b0;
			tx_want <= 1'b0;
			tx_req  <= 1'b0;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			case (state_q)
				TX_IDLE:
				begin
					if (dev_req)
					begin
						tx_want <= framed;
						state_q <= framed ? TX_WAIT_GRANT : TX_SKIP;
					end
				end
				// Unframed command is just acknowledged
				TX_SKIP:
				begin
					dev_ack <= 1'b1;
					state_q <= TX_DEV_ACK;
				end
				TX_WAIT_GRANT:
				begin
					if (tx_grant)
					begin
						tx_req  <= 1'b1;
						state_q <= TX_HDR;
					end
				end
				TX_HDR:
				begin
					if (tx_ack)
					begin
						tx_req  <= 1'b0;
						state_q <= TX_HDR_GAP;
					end
				end
				TX_HDR_GAP:
				begin
					// Payload follows once the header ack is down
					if (!tx_ack)
					begin
						tx_req  <= 1'b1;
						state_q <= TX_PAY;
					end
				end
				TX_PAY:
				begin
					if (tx_ack)
					begin
						tx_req  <= 1'b0;
						state_q <= TX_PAY_GAP;
					end
				end
				TX_PAY_GAP:
				begin
					// Frame complete, hand the link back
					if (!tx_ack)
					begin
						tx_want <= 1'b0;
						tx_done <= 1'b1;
						dev_ack <= 1'b1;
						state_q <= TX_DEV_ACK;
					end
				end
				TX_DEV_ACK:
				begin
					if (!dev_req)
					begin
						dev_ack <= 1'b0;
						state_q <= TX_IDLE;
					end
				end
				default:
					state_q <= TX_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// Request latch and outgoing byte
	// --------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if ((state_q == TX_IDLE) && dev_req)
			msg_q <= dev_msg;
		// Byte changes only as its req rises
		if ((state_q == TX_WAIT_GRANT) && tx_grant)
			tx_byte <= hdr_byte;
		if ((state_q == TX_HDR_GAP) && !tx_ack)
			tx_byte <= msg_q.payload;
	end

endmodule

`default_nettype wire

/* src/endpoint_bridge.sv */
// Byte link endpoint bridge
`timescale 1ns/1ps
`default_nettype none

module endpoint_bridge
	import ep_pkg::*;
(
	input  wire               CLK,
	input  wire               RST_N,
	// Host receive side
	input  logic              rx_req,
	input  logic [BYTE_W-1:0] rx_byte,
	output logic              rx_ack,
	// Host transmit side
	output logic              tx_req,
	output logic [BYTE_W-1:0] tx_byte,
	input  logic              tx_ack,
	// Link held by the framer
	output logic              link_busy,
	// Device request side
	input  logic              dev_req,
	input  dev_msg_t          dev_msg,
	output logic              dev_ack,
	// Delivery side
	output logic              uc_in_valid,
	output dev_msg_t          uc_in_msg
);

	// --------------------------------------------------
	// Arbitration nets
	// --------------------------------------------------
	logic rx_grant;
	logic tx_grant;
	logic tx_want;
	logic rx_done;
	logic tx_done;

	// Shares the half duplex link between the two directions
	link_arbiter arb0 (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.rx_req    (rx_req),
		.tx_want   (tx_want),
		.rx_done   (rx_done),
		.tx_done   (tx_done),
		.rx_grant  (rx_grant),
		.tx_grant  (tx_grant),
		.link_busy (link_busy)
	);

	// Host to device messages
	host_rx_decoder rxd0 (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.rx_req      (rx_req),
		.rx_byte     (rx_byte),
		.rx_grant    (rx_grant),
		.rx_ack      (rx_ack),
		.rx_done     (rx_done),
		.uc_in_valid (uc_in_valid),
		.uc_in_msg   (uc_in_msg)
	);

	// Device to host frames
	host_tx_framer txf0 (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.dev_req  (dev_req),
		.dev_msg  (dev_msg),
		.dev_ack  (dev_ack),
		.tx_want  (tx_want),
		.tx_grant (tx_grant),
		.tx_req   (tx_req),
		.tx_byte  (tx_byte),
		.tx_ack   (tx_ack),
		.tx_done  (tx_done)
	);

endmodule

`default_nettype wire

/* tests/tb_link_tasks.svh */
// Host and device link drivers
`ifndef TB_LINK_TASKS_SVH
`define TB_LINK_TASKS_SVH

// --------------------------------------------------
// Host sender
// --------------------------------------------------
// One four-phase exchange on the rx side
task automatic send_host_byte(input logic [BYTE_W-1:0] b);
	int gap;
	gap = rand_below(STALL_MAX + 1);
	repeat (gap) next_cycle();
	assert (!rx_ack) else fail_check("rx_ack still high at a new rx_req");
	rx_byte = b;
	rx_req  = 1'b1;
	while (!rx_ack)
		next_cycle();
	rx_req = 1'b0;
	while (rx_ack)
		next_cycle();
endtask

// Stray byte, or a control byte followed by its data byte
task automatic send_host_message();
	int                kind;
	logic [CMD_W-1:0]  cmd;
	logic [ADDR_W-1:0] addr;
	logic [BYTE_W-1:0] data;
	logic [TAG_W-1:0]  tag;
	kind = rand_below(4);
	addr = ADDR_W'(rand_below(8));
	data = BYTE_W'(rand_below(256));
	if (kind == 3)
	begin
		// Any tag except the control tag
		tag = TAG_W'(rand_below(3));
		if (tag == TAG_CTRL)
			tag = 2'b11;
		send_host_byte({tag, CMD_W'(rand_below(8)), addr});
	end
	else
	begin
		if (kind == 0)
			cmd = CMD_TRIGGER;
		else if (kind == 1)
			cmd = CMD_TRANSFER;
		else
			cmd = other_cmd();
		// Only trigger and transfer reach the device
		if (is_framed(cmd))
			exp_deliv.push_back(expected_delivery(cmd, addr, data));
		send_host_byte({TAG_CTRL, cmd, addr});
		send_host_byte(data);
	end
endtask

// --------------------------------------------------
// Host receiver
// --------------------------------------------------
// Acks tx bytes after random stalls on both phases
task automatic receive_host_bytes();
	logic [BYTE_W-1:0] expected;
	int                stall;
	forever
	begin
		next_cycle();
		if (tx_req)
		begin
			assert (exp_tx.size() != 0) else fail_check("tx_req with no frame byte expected");
			expected = exp_tx.pop_front();
			assert (tx_byte == expected)
			else fail_check($sformatf("tx_byte %h, expected %h", tx_byte, expected));
			n_tx++;
			stall = rand_below(STALL_MAX + 1);
			repeat (stall) next_cycle();
			tx_ack = 1'b1;
			while (tx_req)
				next_cycle();
			stall = rand_below(STALL_MAX + 1);
			repeat (stall) next_cycle();
			tx_ack = 1'b0;
		end
	end
endtask

// --------------------------------------------------
// Device requester
// --------------------------------------------------
task automatic send_dev_request();
	dev_msg_t m;
	int       gap;
	int       kind;
	int       cycles;
	gap = rand_below(STALL_MAX + 1);
	repeat (gap) next_cycle();
	kind      = rand_below(3);
	m.addr    = ADDR_W'(rand_below(8));
	m.payload = BYTE_W'(rand_below(256));
	m.cmd     = (kind == 0) ? CMD_TRIGGER : ((kind == 1) ? CMD_TRANSFER : other_cmd());
	// Header then payload
	if (is_framed(m.cmd))
	begin
		exp_tx.push_back({TAG_HDR, m.cmd, m.addr});
		exp_tx.push_back(m.payload);
	end
	assert (!dev_ack) else fail_check("dev_ack still high at a new dev_req");
	dev_msg = m;
	dev_req = 1'b1;
	cycles  = 0;
	while (!dev_ack)
	begin
		next_cycle();
		cycles++;
	end
	assert ((exp_tx.size() == 0) && !tx_req && !tx_ack)
	else fail_check("dev_ack rose before the frame was fully sent");
	if (!is_framed(m.cmd))
	begin
		assert (cycles == 2)
		else fail_check($sformatf("unframed dev_ack after %0d cycles, expected 2", cycles));
	end
	dev_req = 1'b0;
	while (dev_ack)
		next_cycle();
endtask

`endif

/* tests/tb_endpoint_bridge.sv */
// Endpoint bridge testbench
`timescale 1ns/1ps
`default_nettype none

module tb_endpoint_bridge
	import ep_pkg::*;
();

	// --------------------------------------------------
	// Run length and timing
	// --------------------------------------------------
	localparam int CLK_PERIOD = 40;
	localparam int DRV_DLY    = 2;
	localparam int RST_CYCLES = 10;
	localparam int N_HOST     = 40;
	localparam int N_DEV      = 40;
	// Longest random gap or ack stall, in cycles
	localparam int STALL_MAX  = 4;
	// Worst case for one message, including a wait for the other direction
	localparam int MSG_CYCLES = 8 * (STALL_MAX + 8);
	localparam int N_MSGS     = 2 * (N_HOST + N_DEV);
	localparam int TIMEOUT_CYCLES = RST_CYCLES + N_MSGS * MSG_CYCLES + 100;

	logic              CLK;
	logic              RST_N;
	logic              rx_req;
	logic [BYTE_W-1:0] rx_byte;
	logic              rx_ack;
	logic              tx_req;
	logic [BYTE_W-1:0] tx_byte;
	logic              tx_ack;
	logic              link_busy;
	logic              dev_req;
	dev_msg_t          dev_msg;
	logic              dev_ack;
	logic              uc_in_valid;
	dev_msg_t          uc_in_msg;

	integer seed;

	// Scoreboard queues, filled by the drivers
	dev_msg_t          exp_deliv[$];
	logic [BYTE_W-1:0] exp_tx[$];
	int                n_deliv;
	int                n_tx;

	// Monitor history, sampled at the falling edge
	logic              valid_prev;
	logic              rx_ack_prev;
	logic              tx_req_prev;
	logic [BYTE_W-1:0] tx_byte_held;
	link_owner_t       owner_seen;
	dev_msg_t          deliv_expected;
	// From the first tx_req of a frame until its dev_ack
	logic              frame_open;

	endpoint_bridge dut0 (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.rx_req      (rx_req),
		.rx_byte     (rx_byte),
		.rx_ack      (rx_ack),
		.tx_req      (tx_req),
		.tx_byte     (tx_byte),
		.tx_ack      (tx_ack),
		.link_busy   (link_busy),
		.dev_req     (dev_req),
		.dev_msg     (dev_msg),
		.dev_ack     (dev_ack),
		.uc_in_valid (uc_in_valid),
		.uc_in_msg   (uc_in_msg)
	);

	initial
	begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// --------------------------------------------------
	// Helpers and reference model
	// --------------------------------------------------
	task automatic fail_check(input string msg);
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped on a failed check");
	endtask

	// Drivers act just after the rising edge
	task automatic next_cycle();
		@(posedge CLK);
		#DRV_DLY;
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic is_framed(input logic [CMD_W-1:0] cmd);
		return (cmd == CMD_TRIGGER) || (cmd == CMD_TRANSFER);
	endfunction

	// Any code other than trigger and transfer
	function automatic logic [CMD_W-1:0] other_cmd();
		logic [CMD_W-1:0] c;
		c = CMD_W'(rand_below(6));
		if (c != '0)
			c = c + 3'd2;
		return c;
	endfunction

	// Trigger drops the address, transfer keeps it
	function automatic dev_msg_t expected_delivery(input logic [CMD_W-1:0] cmd,
		input logic [ADDR_W-1:0] addr, input logic [BYTE_W-1:0] data);
		dev_msg_t m;
		m.cmd     = cmd;
		m.addr    = (cmd == CMD_TRIGGER) ? '0 : addr;
		m.payload = data;
		return m;
	endfunction

	`include "tb_link_tasks.svh"

	// --------------------------------------------------
	// Monitors
	// --------------------------------------------------
	always @(negedge CLK)
	begin
		if (RST_N)
		begin
			assert (!(rx_ack && link_busy))
			else fail_check($sformatf("rx_ack high while link_busy, owner was %s",
				owner_seen.name()));
			assert (!tx_req || link_busy) else fail_check("tx_req high without link_busy");
			// No host byte taken between header and payload
			assert (!(frame_open && rx_ack))
			else fail_check("rx_ack high inside a tx frame");
			// Byte must hold for the whole req phase
			if (tx_req && tx_req_prev)
			begin
				assert (tx_byte == tx_byte_held)
				else fail_check($sformatf("tx_byte moved from %h to %h during tx_req",
					tx_byte_held, tx_byte));
			end
		end
		if (tx_req)
			frame_open = 1'b1;
		else if (dev_ack)
			frame_open = 1'b0;
		tx_req_prev  = tx_req;
		tx_byte_held = tx_byte;
		owner_seen   = link_busy ? OWNER_TX : (rx_ack ? OWNER_RX : OWNER_NONE);
	end

	// Delivered messages against the model queue
	always @(negedge CLK)
	begin
		if (RST_N && uc_in_valid)
		begin
			assert (!valid_prev) else fail_check("uc_in_valid high for more than one cycle");
			assert (rx_ack && !rx_ack_prev)
			else fail_check("uc_in_valid not in the cycle the data rx_ack rises");
			assert (exp_deliv.size() != 0) else fail_check("uc_in_valid with no message expected");
			deliv_expected = exp_deliv.pop_front();
			assert (uc_in_msg == deliv_expected)
			else fail_check($sformatf("uc_in_msg %h, expected %h", uc_in_msg, deliv_expected));
			n_deliv++;
		end
		valid_prev  = uc_in_valid;
		rx_ack_prev = rx_ack;
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		seed        = 32'h3ba9_5bbd;
		RST_N       = 1'b0;
		rx_req      = 1'b0;
		rx_byte     = '0;
		tx_ack      = 1'b0;
		dev_req     = 1'b0;
		dev_msg     = '0;
		n_deliv     = 0;
		n_tx        = 0;
		valid_prev  = 1'b0;
		rx_ack_prev = 1'b0;
		tx_req_prev = 1'b0;
		frame_open  = 1'b0;
		owner_seen  = OWNER_NONE;
		repeat (RST_CYCLES) @(posedge CLK);
		#DRV_DLY;
		RST_N = 1'b1;
		next_cycle();
		assert (!rx_ack && !tx_req && !dev_ack && !uc_in_valid && !link_busy)
		else fail_check("outputs not idle after reset");

		fork
			receive_host_bytes();
		join_none

		// Each direction alone, then both at once
		repeat (N_HOST) send_host_message();
		repeat (N_DEV) send_dev_request();
		fork
			repeat (N_HOST) send_host_message();
			repeat (N_DEV) send_dev_request();
		join
		repeat (STALL_MAX + 4) next_cycle();

		$display("%0d messages delivered, %0d bytes framed", n_deliv, n_tx);
		if ((exp_deliv.size() == 0) && (exp_tx.size() == 0))
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
		begin
			fail_check($sformatf("%0d deliveries and %0d tx bytes still expected",
				exp_deliv.size(), exp_tx.size()));
		end
	end

	// Ends a run that stops making progress
	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the DUT stopped responding",
			TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+tests
src/ep_pkg.sv
src/link_arbiter.sv
src/host_rx_decoder.sv
src/host_tx_framer.sv
src/endpoint_bridge.sv
tests/tb_endpoint_bridge.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        = tb_endpoint_bridge
RTL_TOP    = endpoint_bridge
FLIST      = flist.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
